//--- design/pw_pkg.sv
package pw_pkg;

   //////////////////////////////////////////////////////////////////////
   // register map, 8-bit addresses on the wishbone slave
   //////////////////////////////////////////////////////////////////////
   localparam logic [7:0] REG_ARM            = 8'h00; // w: bit 0 arms, r: status
   localparam logic [7:0] REG_PATTERN_BYTES  = 8'h01;
   localparam logic [7:0] REG_CAPTURE_LEN_LO = 8'h02;
   localparam logic [7:0] REG_CAPTURE_LEN_HI = 8'h03;
   localparam logic [7:0] REG_TRIG_DELAY_LO  = 8'h04;
   localparam logic [7:0] REG_TRIG_DELAY_HI  = 8'h05;
   localparam logic [7:0] REG_TRIG_WIDTH_LO  = 8'h06;
   localparam logic [7:0] REG_TRIG_WIDTH_HI  = 8'h07;
   localparam logic [7:0] REG_FIFO_DATA      = 8'h08;
   localparam logic [7:0] REG_FIFO_TIME      = 8'h09;
   localparam logic [7:0] REG_FIFO_KIND      = 8'h0A; // read pops the fifo
   localparam logic [7:0] REG_PATTERN_BASE   = 8'h10; // one byte per pattern byte
   localparam logic [7:0] REG_MASK_BASE      = 8'h18;

   localparam int TIME_DELTA_WIDTH = 6;  // saturating
   localparam int COUNT_WIDTH      = 16;

   typedef enum logic [1:0] {
      KIND_DATA    = 2'd0,
      KIND_PKT_END = 2'd1
   } entry_kind_e;

   typedef struct packed {
      entry_kind_e                 kind;
      logic [7:0]                  data;
      logic [TIME_DELTA_WIDTH-1:0] delta;
   } capture_entry_t;

   // utmi receive side of the front end
   typedef struct packed {
      logic [7:0] data;
      logic       rxvalid;
      logic       rxactive;
      logic       rxerror;
   } utmi_rx_t;

   typedef struct packed {
      logic [COUNT_WIDTH-1:0] delay;
      logic [COUNT_WIDTH-1:0] width;
   } trig_cfg_t;

   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [7:0] adr;
      logic [7:0] dat;
   } wb_req_t;

endpackage

//--- design/capture_fifo.sv
module capture_fifo import pw_pkg::*; #(
   parameter int FIFO_DEPTH = 16  // power of two
) (
   input  logic           fe_clk,
   input  logic           rst_i,
   input  logic           wr_i,
   input  capture_entry_t entry_i,
   input  logic           pop_i,
   output capture_entry_t head_o,
   output logic           empty_o,
   output logic           full_o
);

   localparam int               AW    = $clog2(FIFO_DEPTH);
   localparam logic [AW:0]      DEPTH = (AW+1)'(FIFO_DEPTH);

   capture_entry_t mem [FIFO_DEPTH];
   logic [AW-1:0]  wr_ptr_q;
   logic [AW-1:0]  rd_ptr_q;
   logic [AW:0]    count_q;

   assign head_o  = mem[rd_ptr_q];  // first word falls through
   assign empty_o = (count_q == '0);
   // also high when this cycle's write takes the last slot
   assign full_o  = (count_q == DEPTH) ||
                    ((count_q == DEPTH - 1'b1) && wr_i && !pop_i);

   always_ff @(posedge fe_clk) begin
      if (wr_i) mem[wr_ptr_q] <= entry_i;
   end

   //////////////////////////////////////////////////////////////////////
   // pointers and fill count
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_i) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({wr_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: ;  // both or neither
         endcase
      end
   end

   // register block only pops a valid head
   a_no_pop_empty: assert property (@(posedge fe_clk) disable iff (rst_i)
      pop_i |-> !empty_o);

endmodule

//--- design/capture_ctrl.sv
module capture_ctrl import pw_pkg::*; (
   input  logic                   fe_clk,
   input  logic                   rst_i,
   input  utmi_rx_t               utmi_i,
   input  logic                   match_i,
   input  logic                   armed_i,
   input  logic [COUNT_WIDTH-1:0] capture_len_i,
   input  logic                   fifo_full_i,
   output capture_entry_t         entry_o,
   output logic                   entry_wr_o,
   output logic                   capturing_o,
   output logic                   capture_done_o
);

   localparam logic [TIME_DELTA_WIDTH-1:0] DELTA_MAX = '1;

   logic                        armed_q;
   logic                        rxactive_q;
   logic [COUNT_WIDTH-1:0]      count_q;  // data entries this arm
   logic [TIME_DELTA_WIDTH-1:0] delta_q;
   logic [TIME_DELTA_WIDTH-1:0] delta_cur;
   logic                        run;
   logic                        len_zero;
   logic                        active;
   logic                        take_data;
   logic                        take_end;
   logic                        stop;

   // the byte right after the completing one arrives with the match pulse
   assign run       = capturing_o | match_i;
   assign len_zero  = (capture_len_i == '0);
   assign active    = run & ~fifo_full_i & ~len_zero;
   assign take_data = active & utmi_i.rxvalid;
   assign take_end  = active & ~utmi_i.rxvalid & rxactive_q & ~utmi_i.rxactive;
   assign stop      = run & (fifo_full_i | len_zero |
                             (take_data & (count_q == capture_len_i - 1'b1)));
   assign delta_cur = match_i ? TIME_DELTA_WIDTH'(1) : delta_q;  // counted from the match

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         armed_q        <= 1'b0;
         rxactive_q     <= 1'b0;
         count_q        <= '0;
         delta_q        <= '0;
         entry_wr_o     <= 1'b0;
         capturing_o    <= 1'b0;
         capture_done_o <= 1'b0;
      end else begin
         armed_q    <= armed_i;
         rxactive_q <= utmi_i.rxactive;
         entry_wr_o <= take_data | take_end;
         if (take_data || take_end) delta_q <= TIME_DELTA_WIDTH'(1);
         else if (delta_cur != DELTA_MAX) delta_q <= delta_cur + 1'b1;
         else delta_q <= delta_cur;  // saturated
         if (armed_i && !armed_q) begin  // fresh arm
            count_q        <= '0;
            capture_done_o <= 1'b0;
         end else if (take_data) begin
            count_q <= count_q + 1'b1;
         end
         if (stop) begin
            capturing_o    <= 1'b0;
            capture_done_o <= 1'b1;
         end else if (match_i) begin
            capturing_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      if (take_data || take_end) begin
         entry_o.kind  <= take_data ? KIND_DATA : KIND_PKT_END;
         entry_o.data  <= take_data ? utmi_i.data : 8'h00;
         entry_o.delta <= delta_cur;
      end
   end

   // fifo full looks ahead one write, so the entry in flight always fits
   a_no_wr_full: assert property (@(posedge fe_clk) disable iff (rst_i)
      entry_wr_o |-> !$past(fifo_full_i));

endmodule

//--- design/pw_trigger.sv
module pw_trigger import pw_pkg::*; (
   input  logic      fe_clk,
   input  logic      rst_i,
   input  logic      match_i,
   input  trig_cfg_t trig_cfg_i,
   output logic      trig_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DELAY,
      ST_PULSE
   } state_e;

   state_e                 state_q;
   logic [COUNT_WIDTH-1:0] cnt_q;  // cycles left in the current state

   //////////////////////////////////////////////////////////////////////
   // idle -> delay -> pulse, matches outside idle are dropped
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (match_i && trig_cfg_i.width != '0) begin  // zero width, no pulse
                  if (trig_cfg_i.delay == '0) begin
                     state_q <= ST_PULSE;
                     cnt_q   <= trig_cfg_i.width - 1'b1;
                  end else begin
                     state_q <= ST_DELAY;
                     cnt_q   <= trig_cfg_i.delay - 1'b1;
                  end
               end
            end
            ST_DELAY: begin
               if (cnt_q == '0) begin
                  state_q <= ST_PULSE;
                  cnt_q   <= trig_cfg_i.width - 1'b1;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            ST_PULSE: begin
               if (cnt_q == '0) state_q <= ST_IDLE;
               else cnt_q <= cnt_q - 1'b1;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   assign trig_o = (state_q == ST_PULSE);

endmodule

//--- design/pattern_matcher.sv
module pattern_matcher import pw_pkg::*; #(
   parameter int PATTERN_BYTES = 8
) (
   input  logic                       fe_clk,
   input  logic                       rst_i,
   input  utmi_rx_t                   utmi_i,
   input  logic [PATTERN_BYTES*8-1:0] pattern_i,
   input  logic [PATTERN_BYTES*8-1:0] mask_i,
   input  logic [7:0]                 pattern_bytes_i,
   input  logic                       armed_i,
   input  logic                       capturing_i,
   output logic                       match_o
);

   logic [PATTERN_BYTES-1:0][7:0] pat;
   logic [PATTERN_BYTES-1:0][7:0] msk;
   logic [PATTERN_BYTES-1:0][7:0] hist_q;  // [0] is the newest byte
   logic [PATTERN_BYTES-1:0][7:0] hist_d;
   logic [7:0]                    fill_q;
   logic [7:0]                    fill_d;
   logic                          rxactive_q;
   logic                          fired_q;
   logic                          byte_ok;
   logic                          len_ok;
   logic                          hit;

   assign pat     = pattern_i;
   assign msk     = mask_i;
   assign byte_ok = utmi_i.rxvalid & ~utmi_i.rxerror;

   // history restarts with every packet, an rx error spoils it too
   always_comb begin
      hist_d = hist_q;
      fill_d = fill_q;
      if ((utmi_i.rxactive && !rxactive_q) || utmi_i.rxerror) begin
         hist_d = '0;
         fill_d = 8'h00;
      end
      if (byte_ok) begin
         hist_d = {hist_d[PATTERN_BYTES-2:0], utmi_i.data};
         if (fill_d < PATTERN_BYTES) fill_d = fill_d + 8'd1;
      end
   end

   // newest byte lines up with pattern byte pattern_bytes-1
   always_comb begin
      int k;
      len_ok = (pattern_bytes_i != 8'h00) && (pattern_bytes_i <= PATTERN_BYTES) &&
               (fill_d >= pattern_bytes_i);
      hit    = len_ok & byte_ok;
      for (int j = 0; j < PATTERN_BYTES; j++) begin
         k = int'(pattern_bytes_i) - 1 - j;
         if (len_ok && k >= 0) begin
            if (((hist_d[j] ^ pat[k]) & msk[k]) != 8'h00) hit = 1'b0;
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      hist_q <= hist_d;
   end

   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         fill_q     <= 8'h00;
         rxactive_q <= 1'b0;
         fired_q    <= 1'b0;
         match_o    <= 1'b0;
      end else begin
         fill_q     <= fill_d;
         rxactive_q <= utmi_i.rxactive;
         match_o    <= hit & armed_i & ~capturing_i & ~fired_q;
         if (!armed_i) fired_q <= 1'b0;
         else if (hit && !capturing_i) fired_q <= 1'b1;  // once per arm
      end
   end

   // arm flag in the register block must still be up when the pulse lands
   a_match_armed: assert property (@(posedge fe_clk) disable iff (rst_i)
      match_o |-> armed_i);

endmodule

//--- design/pw_regs.sv
module pw_regs import pw_pkg::*; #(
   parameter int PATTERN_BYTES = 8
) (
   input  logic                       fe_clk,
   input  logic                       rst_i,
   input  wb_req_t                    wb_i,
   output logic [7:0]                 wb_dat_o,
   output logic                       wb_ack_o,
   output logic [PATTERN_BYTES*8-1:0] pattern_o,
   output logic [PATTERN_BYTES*8-1:0] mask_o,
   output logic [7:0]                 pattern_bytes_o,
   output trig_cfg_t                  trig_cfg_o,
   output logic [COUNT_WIDTH-1:0]     capture_len_o,
   output logic                       armed_o,
   input  logic                       capturing_i,
   input  logic                       capture_done_i,
   input  capture_entry_t             fifo_head_i,
   input  logic                       fifo_empty_i,
   output logic                       fifo_pop_o
);

   logic [PATTERN_BYTES-1:0][7:0] pattern_q;
   logic [PATTERN_BYTES-1:0][7:0] mask_q;
   logic [7:0]                    pattern_bytes_q;
   logic [COUNT_WIDTH-1:0]        capture_len_q;
   logic [COUNT_WIDTH-1:0]        trig_delay_q;
   logic [COUNT_WIDTH-1:0]        trig_width_q;
   logic                          done_q;
   logic                          req;
   logic                          wr_en;
   logic [7:0]                    rd_data;
   capture_entry_t                head;

   assign req   = wb_i.cyc & wb_i.stb & ~wb_ack_o; // new cycle, not yet acked
   assign wr_en = req & wb_i.we;
   assign head  = fifo_empty_i ? '0 : fifo_head_i;  // empty fifo reads zero

   assign pattern_o       = pattern_q;
   assign mask_o          = mask_q;
   assign pattern_bytes_o = pattern_bytes_q;
   assign capture_len_o   = capture_len_q;
   assign trig_cfg_o      = '{delay: trig_delay_q, width: trig_width_q};

   // head leaves the fifo at the end of the kind read
   assign fifo_pop_o = wb_ack_o & ~wb_i.we & (wb_i.adr == REG_FIFO_KIND) & ~fifo_empty_i;

   //////////////////////////////////////////////////////////////////////
   // read mux
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      rd_data = 8'h00;  // unmapped
      case (wb_i.adr)
         REG_ARM:            rd_data = {4'b0, capture_done_i, fifo_empty_i, capturing_i, armed_o};
         REG_PATTERN_BYTES:  rd_data = pattern_bytes_q;
         REG_CAPTURE_LEN_LO: rd_data = capture_len_q[7:0];
         REG_CAPTURE_LEN_HI: rd_data = capture_len_q[15:8];
         REG_TRIG_DELAY_LO:  rd_data = trig_delay_q[7:0];
         REG_TRIG_DELAY_HI:  rd_data = trig_delay_q[15:8];
         REG_TRIG_WIDTH_LO:  rd_data = trig_width_q[7:0];
         REG_TRIG_WIDTH_HI:  rd_data = trig_width_q[15:8];
         REG_FIFO_DATA:      rd_data = head.data;
         REG_FIFO_TIME:      rd_data = 8'(head.delta);
         REG_FIFO_KIND:      rd_data = 8'(head.kind);
         default: ;
      endcase
      for (int i = 0; i < PATTERN_BYTES; i++) begin
         if (wb_i.adr == REG_PATTERN_BASE + 8'(i)) rd_data = pattern_q[i];
         if (wb_i.adr == REG_MASK_BASE + 8'(i))    rd_data = mask_q[i];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // ack, configuration writes, arm flag
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge fe_clk) begin
      if (rst_i) begin
         wb_ack_o        <= 1'b0;
         armed_o         <= 1'b0;
         done_q          <= 1'b0;
         pattern_q       <= '0;
         mask_q          <= '0;
         pattern_bytes_q <= 8'h00;
         capture_len_q   <= '0;
         trig_delay_q    <= '0;
         trig_width_q    <= '0;
      end else begin
         wb_ack_o <= req;
         done_q   <= capture_done_i;
         if (capture_done_i && !done_q) armed_o <= 1'b0;  // one shot per arm
         if (wr_en) begin
            case (wb_i.adr)
               REG_ARM:            armed_o              <= wb_i.dat[0];
               REG_PATTERN_BYTES:  pattern_bytes_q      <= wb_i.dat;
               REG_CAPTURE_LEN_LO: capture_len_q[7:0]   <= wb_i.dat;
               REG_CAPTURE_LEN_HI: capture_len_q[15:8]  <= wb_i.dat;
               REG_TRIG_DELAY_LO:  trig_delay_q[7:0]    <= wb_i.dat;
               REG_TRIG_DELAY_HI:  trig_delay_q[15:8]   <= wb_i.dat;
               REG_TRIG_WIDTH_LO:  trig_width_q[7:0]    <= wb_i.dat;
               REG_TRIG_WIDTH_HI:  trig_width_q[15:8]   <= wb_i.dat;
               default: ;
            endcase
            for (int i = 0; i < PATTERN_BYTES; i++) begin
               if (wb_i.adr == REG_PATTERN_BASE + 8'(i)) pattern_q[i] <= wb_i.dat;
               if (wb_i.adr == REG_MASK_BASE + 8'(i))    mask_q[i]    <= wb_i.dat;
            end
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      if (req) wb_dat_o <= rd_data;  // valid in the ack cycle
   end

   // classic handshake, single cycle ack
   a_ack_single: assert property (@(posedge fe_clk) disable iff (rst_i)
      wb_ack_o |=> !wb_ack_o);

endmodule

//--- design/pw_sniffer_top.sv
module pw_sniffer_top import pw_pkg::*; #(
   parameter int PATTERN_BYTES = 8,
   parameter int FIFO_DEPTH    = 16
) (
   input  logic       fe_clk,
   input  logic       rst_i,
   input  wb_req_t    wb_i,
   output logic [7:0] wb_dat_o,
   output logic       wb_ack_o,
   input  utmi_rx_t   utmi_i,
   output logic       cw_trig_o,
   output logic       mcx_trig_o,
   output logic       led_cap_o,
   output logic       led_trig_o
);

   logic [PATTERN_BYTES*8-1:0] pattern;
   logic [PATTERN_BYTES*8-1:0] mask;
   logic [7:0]                 pattern_bytes;
   trig_cfg_t                  trig_cfg;
   logic [COUNT_WIDTH-1:0]     capture_len;
   logic                       armed;
   logic                       capturing;
   logic                       capture_done;
   logic                       match;
   capture_entry_t             entry;
   logic                       entry_wr;
   capture_entry_t             fifo_head;
   logic                       fifo_empty;
   logic                       fifo_full;
   logic                       fifo_pop;

   assign mcx_trig_o = cw_trig_o;  // same pulse on both connectors
   assign led_cap_o  = armed;
   assign led_trig_o = capturing;

   pw_regs #(
      .PATTERN_BYTES (PATTERN_BYTES)
   ) i_pw_regs (
      .fe_clk          (fe_clk),
      .rst_i           (rst_i),
      .wb_i            (wb_i),
      .wb_dat_o        (wb_dat_o),
      .wb_ack_o        (wb_ack_o),
      .pattern_o       (pattern),
      .mask_o          (mask),
      .pattern_bytes_o (pattern_bytes),
      .trig_cfg_o      (trig_cfg),
      .capture_len_o   (capture_len),
      .armed_o         (armed),
      .capturing_i     (capturing),
      .capture_done_i  (capture_done),
      .fifo_head_i     (fifo_head),
      .fifo_empty_i    (fifo_empty),
      .fifo_pop_o      (fifo_pop)
   );

   pattern_matcher #(
      .PATTERN_BYTES (PATTERN_BYTES)
   ) i_pattern_matcher (
      .fe_clk          (fe_clk),
      .rst_i           (rst_i),
      .utmi_i          (utmi_i),
      .pattern_i       (pattern),
      .mask_i          (mask),
      .pattern_bytes_i (pattern_bytes),
      .armed_i         (armed),
      .capturing_i     (capturing),
      .match_o         (match)
   );

   pw_trigger i_pw_trigger (
      .fe_clk     (fe_clk),
      .rst_i      (rst_i),
      .match_i    (match),
      .trig_cfg_i (trig_cfg),
      .trig_o     (cw_trig_o)
   );

   capture_ctrl i_capture_ctrl (
      .fe_clk         (fe_clk),
      .rst_i          (rst_i),
      .utmi_i         (utmi_i),
      .match_i        (match),
      .armed_i        (armed),
      .capture_len_i  (capture_len),
      .fifo_full_i    (fifo_full),
      .entry_o        (entry),
      .entry_wr_o     (entry_wr),
      .capturing_o    (capturing),
      .capture_done_o (capture_done)
   );

   capture_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_capture_fifo (
      .fe_clk  (fe_clk),
      .rst_i   (rst_i),
      .wr_i    (entry_wr),
      .entry_i (entry),
      .pop_i   (fifo_pop),
      .head_o  (fifo_head),
      .empty_o (fifo_empty),
      .full_o  (fifo_full)
   );

endmodule

//--- tb/tb_pw_sniffer.sv
module tb_pw_sniffer import pw_pkg::*; ();

   localparam int PATTERN_BYTES = 8;
   localparam int FIFO_DEPTH    = 16;
   localparam int CLK_PERIOD    = 4;
   localparam int RESET_CYCLES  = 8;
   localparam int PKT_LEN       = 12;
   localparam int GAP           = 3;
   localparam int TAIL          = 40;   // idle cycles after the second packet
   localparam int NROWS         = 5;
   localparam int ROW_CYCLES    = 400;
   localparam int DELTA_SAT     = (1 << TIME_DELTA_WIDTH) - 1;

   typedef struct packed {
      logic [63:0] pattern;        // byte 0 in bits 7:0
      logic [63:0] mask;
      logic [7:0]  pattern_bytes;
      logic [15:0] delay;
      logic [15:0] width;
      logic [15:0] capture_len;
      logic [95:0] packet;         // packet byte i in bits 8i+7:8i
      logic [11:0] fixed;          // bit i set, byte i taken from the row
   } row_t;

   logic           fe_clk;
   logic           rst_i;
   wb_req_t        wb_req;
   logic [7:0]     wb_rdata;
   logic           wb_ack;
   utmi_rx_t       utmi_rx;
   logic           cw_trig;
   logic           mcx_trig;
   logic           led_cap;
   logic           led_trig;

   row_t           rows [NROWS];
   logic [7:0]     img [PKT_LEN];
   logic [31:0]    lfsr_q;
   capture_entry_t exp_q [$];
   int             match_at;       // completing byte index, -1 when none
   int             trig_rise;
   int             trig_end;
   logic           exp_done;
   logic           saw_capturing;
   int             checks;
   int             errors;

   pw_sniffer_top #(
      .PATTERN_BYTES (PATTERN_BYTES),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) i_pw_sniffer_top (
      .fe_clk     (fe_clk),
      .rst_i      (rst_i),
      .wb_i       (wb_req),
      .wb_dat_o   (wb_rdata),
      .wb_ack_o   (wb_ack),
      .utmi_i     (utmi_rx),
      .cw_trig_o  (cw_trig),
      .mcx_trig_o (mcx_trig),
      .led_cap_o  (led_cap),
      .led_trig_o (led_trig)
   );

   always #(CLK_PERIOD/2) fe_clk = ~fe_clk;

   //////////////////////////////////////////////////////////////////////
   // stimulus table
   //////////////////////////////////////////////////////////////////////
   function automatic void fill_table();
      rows[0] = '{pattern: 64'h4BD2, mask: 64'hFFFF, pattern_bytes: 8'd2, delay: 16'd3,
                  width: 16'd2, capture_len: 16'd6, packet: 96'h4B_D211_C380,
                  fixed: 12'h01F};
      // middle byte masked out and different in the packet
      rows[1] = '{pattern: 64'hA5_5A69, mask: 64'hFF_00FF, pattern_bytes: 8'd3,
                  delay: 16'd0, width: 16'd4, capture_len: 16'd10,
                  packet: 96'hA5776900_00000000_00000000, fixed: 12'hE00};
      rows[2] = '{pattern: 64'hC33C, mask: 64'hFFFF, pattern_bytes: 8'd2, delay: 16'd2,
                  width: 16'd5, capture_len: 16'd4, packet: 96'h3D3C_0000,
                  fixed: 12'h00C};  // near miss
      rows[3] = '{pattern: 64'h96, mask: 64'hF0, pattern_bytes: 8'd1, delay: 16'd1,
                  width: 16'd3, capture_len: 16'h0120, packet: 96'h9B,
                  fixed: 12'h001};  // runs into a full fifo
      rows[4] = '{pattern: 64'h0403_0201, mask: 64'hFFFF_FFFF, pattern_bytes: 8'd4,
                  delay: 16'h0205, width: 16'd0, capture_len: 16'd3,
                  packet: 96'h0403_0201_0000_0000_0000, fixed: 12'h3C0};
   endfunction

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
   endfunction

   task automatic random_byte(output logic [7:0] b);
      for (int n = 0; n < 8; n++) begin
         lfsr_q = lfsr_next(lfsr_q);
         b      = {b[6:0], lfsr_q[0]};
      end
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // wishbone master, entered and left 1 unit after a rising edge
   //////////////////////////////////////////////////////////////////////
   task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdata);
      int waited;
      wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
      waited = 0;
      do begin
         @(posedge fe_clk);
         #1;
         waited++;
      end while (!wb_ack && waited < 8);
      assert (wb_ack) else begin
         errors++;
         $display("no acknowledge from the register slave at address %0h", adr);
      end
      if (wb_ack) check_equal("ack latency", waited, 1);
      rdata      = wb_rdata;
      wb_req.cyc = 1'b0;  // address and we stay for the pop edge
      wb_req.stb = 1'b0;
      @(posedge fe_clk);
      #1;
      check_equal("wb_ack_o", wb_ack, 0);
   endtask

   task automatic write_reg(input logic [7:0] adr, input logic [7:0] dat);
      logic [7:0] unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic read_reg(input logic [7:0] adr, output logic [7:0] dat);
      bus_cycle(1'b0, adr, 8'h00, dat);
   endtask

   task automatic write_checked(input logic [7:0] adr, input logic [7:0] dat,
                                input string name);
      logic [7:0] back;
      write_reg(adr, dat);
      read_reg(adr, back);
      check_equal(name, back, dat);
   endtask

   task automatic configure_row(input row_t r);
      logic [7:0] st;
      write_reg(REG_ARM, 8'h00);
      for (int i = 0; i < PATTERN_BYTES; i++) begin
         write_checked(REG_PATTERN_BASE + 8'(i), r.pattern[8*i +: 8], $sformatf("pattern[%0d]", i));
         write_checked(REG_MASK_BASE + 8'(i), r.mask[8*i +: 8], $sformatf("mask[%0d]", i));
      end
      write_checked(REG_PATTERN_BYTES, r.pattern_bytes, "pattern_bytes");
      write_checked(REG_CAPTURE_LEN_LO, r.capture_len[7:0], "capture_len_lo");
      write_checked(REG_CAPTURE_LEN_HI, r.capture_len[15:8], "capture_len_hi");
      write_checked(REG_TRIG_DELAY_LO, r.delay[7:0], "trig_delay_lo");
      write_checked(REG_TRIG_DELAY_HI, r.delay[15:8], "trig_delay_hi");
      write_checked(REG_TRIG_WIDTH_LO, r.width[7:0], "trig_width_lo");
      write_checked(REG_TRIG_WIDTH_HI, r.width[15:8], "trig_width_hi");
      write_reg(REG_ARM, 8'h01);
      read_reg(REG_ARM, st);
      check_equal("status after arm", st, 8'h05);  // armed and empty
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference model of match, trigger window and fifo contents
   //////////////////////////////////////////////////////////////////////
   task automatic build_expected(input row_t r);
      capture_entry_t ent;
      int             pb;
      int             prev;
      int             ndata;
      int             c;
      logic           hit;
      logic           stopped;
      for (int i = 0; i < PKT_LEN; i++) begin
         if (r.fixed[i]) img[i] = r.packet[8*i +: 8];
         else random_byte(img[i]);
      end
      pb       = int'(r.pattern_bytes);
      match_at = -1;
      for (int i = 0; i < PKT_LEN && match_at < 0; i++) begin
         if (pb >= 1 && pb <= PATTERN_BYTES && i >= pb - 1) begin
            hit = 1'b1;
            for (int j = 0; j < pb; j++)
               if (((img[i-pb+1+j] ^ r.pattern[8*j +: 8]) & r.mask[8*j +: 8]) != 8'h00)
                  hit = 1'b0;
            if (hit) match_at = i;
         end
      end
      exp_q.delete();
      exp_done = 1'b0;
      if (match_at >= 0) begin
         prev    = match_at;  // deltas count from the completing byte
         ndata   = 0;
         stopped = (r.capture_len == 16'd0);
         for (int p = 0; p < 2; p++) begin
            for (int e = 0; e <= PKT_LEN; e++) begin  // e == PKT_LEN is the packet end
               c = p * (PKT_LEN + GAP) + e;
               if (!stopped && c > match_at) begin
                  ent.kind  = (e == PKT_LEN) ? KIND_PKT_END : KIND_DATA;
                  ent.data  = (e == PKT_LEN) ? 8'h00 : img[e];
                  ent.delta = TIME_DELTA_WIDTH'((c - prev > DELTA_SAT) ? DELTA_SAT : c - prev);
                  exp_q.push_back(ent);
                  prev = c;
                  if (e != PKT_LEN) ndata++;
                  if (ndata == int'(r.capture_len) || exp_q.size() == FIFO_DEPTH)
                     stopped = 1'b1;
               end
            end
         end
         exp_done = stopped;
      end
      trig_rise = -1;
      trig_end  = -1;
      if (match_at >= 0 && r.width != 16'd0) begin
         trig_rise = match_at + 2 + int'(r.delay);
         trig_end  = trig_rise + int'(r.width);
      end
   endtask

   // two copies of the packet, one byte per cycle, trigger checked every cycle
   task automatic send_packets();
      int p;
      int e;
      saw_capturing = 1'b0;
      for (int k = 0; k < 2 * (PKT_LEN + GAP) + TAIL; k++) begin
         check_equal("cw_trig_o", cw_trig, (k >= trig_rise && k < trig_end));
         check_equal("mcx_trig_o", mcx_trig, (k >= trig_rise && k < trig_end));
         if (led_trig) saw_capturing = 1'b1;
         p = k / (PKT_LEN + GAP);
         e = k % (PKT_LEN + GAP);
         if (p < 2 && e < PKT_LEN)
            utmi_rx = '{data: img[e], rxvalid: 1'b1, rxactive: 1'b1, rxerror: 1'b0};
         else
            utmi_rx = '0;
         @(posedge fe_clk);
         #1;
      end
      check_equal("capturing seen", saw_capturing, (match_at >= 0));
   endtask

   task automatic drain_fifo();
      logic [7:0] st;
      logic [7:0] exp_st;
      logic [7:0] d;
      logic [7:0] t;
      logic [7:0] kd;
      int         n;
      exp_st = {4'b0, exp_done, 1'b0, (match_at >= 0) && !exp_done, !exp_done};
      exp_st[2] = (exp_q.size() == 0);
      read_reg(REG_ARM, st);
      check_equal("status before drain", st, exp_st);
      check_equal("led_cap_o", led_cap, !exp_done);  // still armed unless capture ended
      n = 0;
      while (!st[2] && n < FIFO_DEPTH + 4) begin
         read_reg(REG_FIFO_DATA, d);
         read_reg(REG_FIFO_TIME, t);
         read_reg(REG_FIFO_KIND, kd);  // pops
         if (n < exp_q.size()) begin
            check_equal($sformatf("entry %0d data", n), d, exp_q[n].data);
            check_equal($sformatf("entry %0d delta", n), t, 8'(exp_q[n].delta));
            check_equal($sformatf("entry %0d kind", n), kd, 8'(exp_q[n].kind));
         end
         n++;
         read_reg(REG_ARM, st);
      end
      check_equal("entries read", n, exp_q.size());
      exp_st[2] = 1'b1;
      check_equal("status after drain", st, exp_st);
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      fe_clk  = 1'b0;
      rst_i   = 1'b1;
      wb_req  = '0;
      utmi_rx = '0;
      lfsr_q  = 32'h8c65_8d0e;
      checks  = 0;
      errors  = 0;
      fill_table();
      repeat (RESET_CYCLES) @(posedge fe_clk);
      #1;
      rst_i = 1'b0;
      check_equal("wb_ack_o", wb_ack, 0);
      check_equal("cw_trig_o", cw_trig, 0);
      check_equal("mcx_trig_o", mcx_trig, 0);
      for (int r = 0; r < NROWS; r++) begin
         build_expected(rows[r]);
         $display("row %0d: match at byte %0d, %0d entries expected", r, match_at,
                  exp_q.size());
         configure_row(rows[r]);
         send_packets();
         drain_fifo();
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // watchdog
   initial begin
      #((NROWS * ROW_CYCLES + RESET_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before all rows completed");
      $display("Errors found");
      $finish;
   end

endmodule

//--- pw_sniffer_top.f
design/pw_pkg.sv
design/capture_fifo.sv
design/capture_ctrl.sv
design/pw_trigger.sv
design/pattern_matcher.sv
design/pw_regs.sv
design/pw_sniffer_top.sv
tb/tb_pw_sniffer.sv

//--- Makefile
# Verilator build and run of the sniffer testbench

TOP := tb_pw_sniffer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f pw_sniffer_top.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
